// ==== hw/isaPkg.sv ====
// ISA definitions: opcodes, register index and the four instruction format views
package isaPkg;

    typedef logic [2:0] regIdxT;

    // Unlisted encodings are illegal
    typedef enum logic [4:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        J     = 5'b00100,
        JR    = 5'b00101,
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        BEQZ  = 5'b01100,
        BNEZ  = 5'b01101,
        ST    = 5'b10000,
        LD    = 5'b10001,
        SLBI  = 5'b10010,
        LBI   = 5'b11000,
        RTYPE = 5'b11011
    } opcodeE;

    // Register to register
    typedef struct packed {
        opcodeE     opcode;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [1:0] func;
    } rFmtT;

    // Two registers and a 5-bit immediate
    typedef struct packed {
        opcodeE     opcode;
        regIdxT     rs;
        regIdxT     rd;
        logic [4:0] imm5;
    } i1FmtT;

    // One register and an 8-bit immediate
    typedef struct packed {
        opcodeE     opcode;
        regIdxT     rs;
        logic [7:0] imm8;
    } i2FmtT;

    // PC-relative jump
    typedef struct packed {
        opcodeE      opcode;
        logic [10:0] disp11;
    } jFmtT;

    typedef union packed {
        rFmtT  rFmt;
        i1FmtT i1Fmt;
        i2FmtT i2Fmt;
        jFmtT  jFmt;
    } instrU;

endpackage

// ==== hw/ctrlPkg.sv ====
// Decode output types: control levels, ALU command, operands and destination tags
package ctrlPkg;

    localparam int dataW = 16;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_JUMP = 2'd1,
        BR_BEQZ = 2'd2,
        BR_BNEZ = 2'd3
    } branchKindE;

    // Order matches the RTYPE func encoding
    typedef enum logic [1:0] {
        ALU_ADD  = 2'd0,
        ALU_SUB  = 2'd1,
        ALU_XOR  = 2'd2,
        ALU_ANDN = 2'd3
    } aluClassE;

    // regSrc: 0 ALU, 1 memory, 2 link PC, 3 immediate
    // bSrc:   0 rt, 1 imm5, 2 imm8, 3 sImm11
    typedef struct packed {
        logic       halt;
        logic       memRead;
        logic       memWrite;
        logic       immSrc;
        logic       aluSign;
        logic       aluJmp;
        logic [1:0] regSrc;
        logic [1:0] bSrc;
        branchKindE branchKind;
        logic       nop;
    } decodeCtrlT;

    typedef struct packed {
        logic [3:0] oper;
        logic       invA;
        logic       invB;
        logic       cin;
    } aluCmdT;

    typedef struct packed {
        logic [dataW-1:0] rsData;
        logic [dataW-1:0] rtData;
        logic [dataW-1:0] imm5;
        logic [dataW-1:0] imm8;
        logic [dataW-1:0] sImm8;
        logic [dataW-1:0] sImm11;
    } operandsT;

    typedef struct packed {
        logic           wen;
        isaPkg::regIdxT idx;
    } destTagT;

endpackage

// ==== hw/controlDecoder.sv ====
// Control decoder: opcode to control levels, ALU class, destination tag and illegal flag
module controlDecoder (
    input  isaPkg::instrU       instr,
    input  logic                stall,
    output ctrlPkg::decodeCtrlT ctrl,
    output ctrlPkg::aluClassE   aluClass,
    output logic                zeroExt,
    output ctrlPkg::destTagT    destNext,
    output logic                illegal
);
    import isaPkg::*;
    import ctrlPkg::*;

    opcodeE opcode;

    // A stalled slot decodes exactly like a NOP
    assign opcode = stall ? NOP : instr.rFmt.opcode;

    always_comb begin
        ctrl     = '0;
        aluClass = ALU_ADD;
        zeroExt  = 1'b0;
        destNext = '0;
        illegal  = 1'b0;
        case (opcode)
            HALT: ctrl.halt = 1'b1;
            NOP:  ctrl.nop  = 1'b1;
            J: begin
                ctrl.branchKind = BR_JUMP;
                ctrl.aluJmp     = 1'b1;
                ctrl.regSrc     = 2'd2;
                ctrl.bSrc       = 2'd3;
                // Link register is r7
                destNext = '{wen: 1'b1, idx: 3'd7};
            end
            JR: begin
                ctrl.branchKind = BR_JUMP;
                ctrl.immSrc     = 1'b1;
                ctrl.bSrc       = 2'd2;
            end
            ADDI, SUBI, XORI, ANDNI: begin
                ctrl.immSrc = 1'b1;
                ctrl.bSrc   = 2'd1;
                destNext    = '{wen: 1'b1, idx: instr.i1Fmt.rd};
                case (opcode)
                    SUBI:    aluClass = ALU_SUB;
                    XORI:    aluClass = ALU_XOR;
                    ANDNI:   aluClass = ALU_ANDN;
                    default: aluClass = ALU_ADD;
                endcase
                // Logic ops take an unsigned immediate
                zeroExt      = (opcode == XORI) || (opcode == ANDNI);
                ctrl.aluSign = !zeroExt;
            end
            BEQZ, BNEZ: begin
                ctrl.branchKind = (opcode == BEQZ) ? BR_BEQZ : BR_BNEZ;
                ctrl.immSrc     = 1'b1;
                ctrl.bSrc       = 2'd2;
            end
            ST, LD: begin
                // Address is rs plus imm5
                ctrl.immSrc   = 1'b1;
                ctrl.bSrc     = 2'd1;
                ctrl.aluSign  = 1'b1;
                ctrl.memWrite = (opcode == ST);
                ctrl.memRead  = (opcode == LD);
                if (opcode == LD) begin
                    ctrl.regSrc = 2'd1;
                    destNext    = '{wen: 1'b1, idx: instr.i1Fmt.rd};
                end
            end
            SLBI, LBI: begin
                ctrl.immSrc = 1'b1;
                ctrl.bSrc   = 2'd2;
                ctrl.regSrc = 2'd3;
                zeroExt     = (opcode == SLBI);
                destNext    = '{wen: 1'b1, idx: instr.i2Fmt.rs};
            end
            RTYPE: begin
                ctrl.aluSign = 1'b1;
                destNext     = '{wen: 1'b1, idx: instr.rFmt.rd};
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// ==== hw/aluControl.sv ====
// ALU control: maps the operation class or RTYPE func to oper and input inversion
module aluControl (
    input  ctrlPkg::aluClassE aluClass,
    input  logic [1:0]        func,
    input  logic              isRType,
    output ctrlPkg::aluCmdT   aluCmd
);
    import ctrlPkg::*;

    aluClassE effClass;

    // RTYPE func bits use the same encoding as the class enum
    assign effClass = isRType ? aluClassE'(func) : aluClass;

    always_comb begin
        aluCmd = '0;
        case (effClass)
            ALU_SUB: begin
                // b - a as ~a + b + 1
                aluCmd.invA = 1'b1;
                aluCmd.cin  = 1'b1;
            end
            ALU_XOR: aluCmd.oper = 4'd1;
            ALU_ANDN: begin
                aluCmd.oper = 4'd2;
                aluCmd.invB = 1'b1;
            end
            default: aluCmd.oper = 4'd0;
        endcase
    end

endmodule

// ==== hw/destPipe.sv ====
// Destination pipe: shifts write tags toward write-back, last stage drives the write strobe
module destPipe #(
    parameter int DEPTH = 3
) (
    input  logic             clk,
    input  logic             rstN,
    input  ctrlPkg::destTagT destNext,
    output ctrlPkg::destTagT pending1,
    output ctrlPkg::destTagT pending2,
    output ctrlPkg::destTagT writeDest
);
    import ctrlPkg::*;

    destTagT stages [DEPTH];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= destNext;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // Taps seen by the hazard unit
    assign pending1  = stages[0];
    assign pending2  = stages[1];
    assign writeDest = stages[DEPTH-1];

endmodule

// ==== hw/regSlice.sv ====
// Register slice: one architectural register with write match and bypass hit detection
module regSlice #(
    parameter int IDX = 0
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  ctrlPkg::destTagT          writeDest,
    input  logic [ctrlPkg::dataW-1:0] wbData,
    input  isaPkg::regIdxT            rsSel,
    input  isaPkg::regIdxT            rtSel,
    output logic [ctrlPkg::dataW-1:0] stored,
    output logic                      rsHit,
    output logic                      rtHit
);
    import isaPkg::*;

    logic wrMatch;

    assign wrMatch = writeDest.wen && (writeDest.idx == regIdxT'(IDX));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stored <= '0;
        end else if (wrMatch) begin
            stored <= wbData;
        end
    end

    // Being written this cycle, so the read must see wbData
    assign rsHit = wrMatch && (rsSel == regIdxT'(IDX));
    assign rtHit = wrMatch && (rtSel == regIdxT'(IDX));

endmodule

// ==== hw/operandMux.sv ====
// Operand mux: selects rs and rt from the register slices with write-back bypass
module operandMux #(
    parameter int NREGS = 8
) (
    input  isaPkg::regIdxT            rsSel,
    input  isaPkg::regIdxT            rtSel,
    input  logic [ctrlPkg::dataW-1:0] stored [NREGS],
    input  logic [NREGS-1:0]          rsHit,
    input  logic [NREGS-1:0]          rtHit,
    input  logic [ctrlPkg::dataW-1:0] wbData,
    output logic [ctrlPkg::dataW-1:0] rsData,
    output logic [ctrlPkg::dataW-1:0] rtData
);

    // At most one slice can hit per port, so any hit means bypass
    assign rsData = (|rsHit) ? wbData : stored[rsSel];
    assign rtData = (|rtHit) ? wbData : stored[rtSel];

endmodule

// ==== hw/decodeStage.sv ====
// Decode stage: control and ALU decode, register file with bypass, immediates and error merge
module decodeStage #(
    parameter int NREGS = 8
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  isaPkg::instrU             instr,
    input  logic                      stall,
    input  logic                      fetchErr,
    input  logic [ctrlPkg::dataW-1:0] wbData,
    output ctrlPkg::decodeCtrlT       ctrl,
    output ctrlPkg::aluCmdT           aluCmd,
    output ctrlPkg::operandsT         operands,
    output ctrlPkg::destTagT          writeDest,
    output ctrlPkg::destTagT          pending1,
    output ctrlPkg::destTagT          pending2,
    output logic                      err
);
    import isaPkg::*;
    import ctrlPkg::*;

    // Write-back lands three stages after decode
    localparam int pipeDepth = 3;

    aluClassE         aluClass;
    logic             zeroExt;
    logic             zext5;
    logic             zext8;
    destTagT          destNext;
    logic             illegal;
    logic             isRType;
    logic [dataW-1:0] regWord [NREGS];
    logic [NREGS-1:0] rsHit;
    logic [NREGS-1:0] rtHit;
    logic [dataW-1:0] rsData;
    logic [dataW-1:0] rtData;

    controlDecoder ctrlDec (
        .instr   (instr),
        .stall   (stall),
        .ctrl    (ctrl),
        .aluClass(aluClass),
        .zeroExt (zeroExt),
        .destNext(destNext),
        .illegal (illegal)
    );

    // Stalled slots must not pick up func bits
    assign isRType = !stall && (instr.rFmt.opcode == RTYPE);

    aluControl aluCtl (
        .aluClass(aluClass),
        .func    (instr.rFmt.func),
        .isRType (isRType),
        .aluCmd  (aluCmd)
    );

    destPipe #(.DEPTH(pipeDepth)) dstPipe (
        .clk      (clk),
        .rstN     (rstN),
        .destNext (destNext),
        .pending1 (pending1),
        .pending2 (pending2),
        .writeDest(writeDest)
    );

    for (genvar i = 0; i < NREGS; i++) begin : gRegs
        regSlice #(.IDX(i)) slice (
            .clk      (clk),
            .rstN     (rstN),
            .writeDest(writeDest),
            .wbData   (wbData),
            .rsSel    (instr.rFmt.rs),
            .rtSel    (instr.rFmt.rt),
            .stored   (regWord[i]),
            .rsHit    (rsHit[i]),
            .rtHit    (rtHit[i])
        );
    end

    operandMux #(.NREGS(NREGS)) opMux (
        .rsSel (instr.rFmt.rs),
        .rtSel (instr.rFmt.rt),
        .stored(regWord),
        .rsHit (rsHit),
        .rtHit (rtHit),
        .wbData(wbData),
        .rsData(rsData),
        .rtData(rtData)
    );

    // SLBI zero-extends imm8
    assign zext8 = zeroExt && (instr.rFmt.opcode == SLBI);
    // XORI and ANDNI zero-extend imm5
    assign zext5 = zeroExt && !zext8;

    always_comb begin
        operands.rsData = rsData;
        operands.rtData = rtData;
        operands.imm5   = zext5 ? {{(dataW-5){1'b0}}, instr.i1Fmt.imm5}
                                : {{(dataW-5){instr.i1Fmt.imm5[4]}}, instr.i1Fmt.imm5};
        operands.sImm8  = {{(dataW-8){instr.i2Fmt.imm8[7]}}, instr.i2Fmt.imm8};
        operands.imm8   = zext8 ? {{(dataW-8){1'b0}}, instr.i2Fmt.imm8} : operands.sImm8;
        operands.sImm11 = {{(dataW-11){instr.jFmt.disp11[10]}}, instr.jFmt.disp11};
    end

    assign err = illegal | fetchErr;

endmodule

// ==== bench/decodeStage_assertions.sv ====
// Destination pipe checks: write strobe quiet around reset and stage two feeding writeDest
module decodeStage_assertions (
    input logic             clk,
    input logic             rstN,
    input ctrlPkg::destTagT pending2,
    input ctrlPkg::destTagT writeDest
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failures seen so far, read by the testbench at the end of the run
    int failCount = 0;

    // No register write in reset or in the first cycle after it
    quietAroundReset: assert property (@(posedge clk)
        !rstN |=> !writeDest.wen ##1 !writeDest.wen)
    else begin
        failCount++;
        $error("writeDest.wen high during or right after reset");
    end

    shiftFromStage2: assert property (@(posedge clk) disable iff (!rstN)
        $past(rstN) |-> writeDest == $past(pending2))
    else begin
        failCount++;
        $error("writeDest does not match pending2 of the previous cycle");
    end

endmodule

bind destPipe decodeStage_assertions chk (
    .clk      (clk),
    .rstN     (rstN),
    .pending2 (pending2),
    .writeDest(writeDest)
);

// ==== bench/decodeStage_tb.sv ====
// Testbench for the decode stage: control decode, register file, bypass and immediates
module decodeStage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import isaPkg::*;
    import ctrlPkg::*;

    localparam int nRegs = 8;
    // Tests take about 130 cycles after reset
    localparam int maxCycles = 400;

    logic             clk = 1'b0;
    logic             rstN;
    instrU            instr;
    logic             stall;
    logic             fetchErr;
    logic [dataW-1:0] wbData;
    decodeCtrlT       ctrl;
    aluCmdT           aluCmd;
    operandsT         operands;
    destTagT          writeDest;
    destTagT          pending1;
    destTagT          pending2;
    logic             err;

    int               seed = 32'h1f4b5d89;
    int               cycles = 0;
    int               checks = 0;
    int               errors = 0;
    int               assertFails;
    // Value each register should hold, also played back as write-back data
    logic [dataW-1:0] regModel [nRegs];
    opcodeE           legalOps [15] = '{HALT, NOP, J, JR, ADDI, SUBI, XORI, ANDNI,
                                        BEQZ, BNEZ, ST, LD, SLBI, LBI, RTYPE};
    opcodeE           immOps [8] = '{ADDI, XORI, ANDNI, SLBI, LBI, J, ST, BEQZ};

    decodeStage #(.NREGS(nRegs)) uut (
        .clk      (clk),
        .rstN     (rstN),
        .instr    (instr),
        .stall    (stall),
        .fetchErr (fetchErr),
        .wbData   (wbData),
        .ctrl     (ctrl),
        .aluCmd   (aluCmd),
        .operands (operands),
        .writeDest(writeDest),
        .pending1 (pending1),
        .pending2 (pending2),
        .err      (err)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic instrU encode(opcodeE op, logic [10:0] rest);
        instrU i;
        i.jFmt.opcode = op;
        i.jFmt.disp11 = rest;
        return i;
    endfunction

    // Flags: halt memRead memWrite immSrc aluSign aluJmp, then regSrc bSrc branch nop
    function automatic decodeCtrlT expCtrl(opcodeE op);
        case (op)
            HALT:         return {6'b100000, 2'd0, 2'd0, BR_NONE, 1'b0};
            NOP:          return {6'b000000, 2'd0, 2'd0, BR_NONE, 1'b1};
            J:            return {6'b000001, 2'd2, 2'd3, BR_JUMP, 1'b0};
            JR:           return {6'b000100, 2'd0, 2'd2, BR_JUMP, 1'b0};
            ADDI, SUBI:   return {6'b000110, 2'd0, 2'd1, BR_NONE, 1'b0};
            XORI, ANDNI:  return {6'b000100, 2'd0, 2'd1, BR_NONE, 1'b0};
            BEQZ:         return {6'b000100, 2'd0, 2'd2, BR_BEQZ, 1'b0};
            BNEZ:         return {6'b000100, 2'd0, 2'd2, BR_BNEZ, 1'b0};
            ST:           return {6'b001110, 2'd0, 2'd1, BR_NONE, 1'b0};
            LD:           return {6'b010110, 2'd1, 2'd1, BR_NONE, 1'b0};
            SLBI, LBI:    return {6'b000100, 2'd3, 2'd2, BR_NONE, 1'b0};
            RTYPE:        return {6'b000010, 2'd0, 2'd0, BR_NONE, 1'b0};
            default:      return '0;
        endcase
    endfunction

    // Class 0 add, 1 sub, 2 xor, 3 andn; result is oper, invA, invB, cin
    function automatic aluCmdT expAlu(opcodeE op, logic [1:0] func);
        logic [1:0] cls;
        case (op)
            RTYPE:   cls = func;
            SUBI:    cls = 2'd1;
            XORI:    cls = 2'd2;
            ANDNI:   cls = 2'd3;
            default: cls = 2'd0;
        endcase
        case (cls)
            2'd1:    return {4'd0, 3'b101};
            2'd2:    return {4'd1, 3'b000};
            2'd3:    return {4'd2, 3'b010};
            default: return {4'd0, 3'b000};
        endcase
    endfunction

    function automatic destTagT expDest(instrU i);
        case (i.rFmt.opcode)
            RTYPE:                       return {1'b1, i.rFmt.rd};
            ADDI, SUBI, XORI, ANDNI, LD: return {1'b1, i.i1Fmt.rd};
            LBI, SLBI:                   return {1'b1, i.i2Fmt.rs};
            J:                           return {1'b1, 3'd7};
            default:                     return '0;
        endcase
    endfunction

    task automatic checkWord(string name, logic [dataW-1:0] got, logic [dataW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkCtrl(string name, decodeCtrlT got, decodeCtrlT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkAlu(string name, aluCmdT got, aluCmdT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkTag(string name, destTagT got, destTagT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Next cycle, with write-back data taken from the register model
    task automatic step();
        @(posedge clk);
        #1;
        wbData = writeDest.wen ? regModel[writeDest.idx] : '0;
    endtask

    task automatic resetTest();
        checkTag("pending1", pending1, '0);
        checkTag("pending2", pending2, '0);
        checkTag("writeDest", writeDest, '0);
        for (int r = 0; r < nRegs; r++) begin
            instr = encode(RTYPE, {3'(r), 3'(r), 3'(r), 2'd0});
            #1;
            checkWord("rsData", operands.rsData, '0);
            checkWord("rtData", operands.rtData, '0);
            checkFlag("err", err, 1'b0);
            step();
        end
    endtask

    task automatic loadTest();
        logic [31:0] rnd;
        destTagT     tag;
        for (int r = 0; r < nRegs; r++) begin
            rnd = $random(seed);
            regModel[r] = rnd[15:0];
            instr = encode(LBI, {3'(r), rnd[7:0]});
            tag = '{wen: 1'b1, idx: 3'(r)};
            step();
            instr = encode(NOP, '0);
            #1;
            checkTag("pending1", pending1, tag);
            step();
            checkTag("pending2", pending2, tag);
            step();
            checkTag("writeDest", writeDest, tag);
        end
        step();
        for (int r = 0; r < nRegs; r++) begin
            instr = encode(RTYPE, {3'(r), 3'(7 - r), 3'(r), 2'd0});
            #1;
            checkWord("rsData", operands.rsData, regModel[r]);
            checkWord("rtData", operands.rtData, regModel[7 - r]);
            step();
        end
    endtask

    task automatic bypassTest();
        logic [31:0]      rnd;
        logic [dataW-1:0] oldVal;
        rnd = $random(seed);
        oldVal = regModel[3];
        // Low bit flipped so the new word always differs from the stored one
        regModel[3] = {rnd[15:1], ~oldVal[0]};
        instr = encode(LBI, {3'd3, rnd[7:0]});
        step();
        instr = encode(NOP, '0);
        step();
        step();
        // writeDest targets r3 now
        instr = encode(RTYPE, {3'd3, 3'd6, 3'd6, 2'd0});
        #1;
        checkWord("rsData bypass", operands.rsData, regModel[3]);
        checkWord("rtData", operands.rtData, regModel[6]);
        step();
        #1;
        checkWord("rsData stored", operands.rsData, regModel[3]);
        step();
    endtask

    task automatic opcodeTest();
        logic [31:0] rnd;
        instrU       ins;
        for (int k = 0; k < 19; k++) begin
            rnd = $random(seed);
            if (k < 15) begin
                ins = encode(legalOps[k], rnd[10:0]);
            end else begin
                ins = encode(RTYPE, {rnd[10:2], 2'(k - 15)});
            end
            instr = ins;
            #1;
            checkCtrl("ctrl", ctrl, expCtrl(ins.rFmt.opcode));
            checkAlu("aluCmd", aluCmd, expAlu(ins.rFmt.opcode, ins.rFmt.func));
            checkFlag("err", err, 1'b0);
            step();
            checkTag("pending1", pending1, expDest(ins));
        end
    endtask

    task automatic immTest();
        logic [31:0] rnd;
        logic        zext5;
        logic        zext8;
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            instr = encode(immOps[k % 8], rnd[10:0]);
            #1;
            // XORI and ANDNI take an unsigned imm5, SLBI an unsigned imm8
            zext5 = immOps[k % 8] inside {XORI, ANDNI};
            zext8 = immOps[k % 8] == SLBI;
            checkWord("imm5", operands.imm5,
                      zext5 ? {11'd0, rnd[4:0]} : {{11{rnd[4]}}, rnd[4:0]});
            checkWord("imm8", operands.imm8,
                      zext8 ? {8'd0, rnd[7:0]} : {{8{rnd[7]}}, rnd[7:0]});
            checkWord("sImm8", operands.sImm8, {{8{rnd[7]}}, rnd[7:0]});
            checkWord("sImm11", operands.sImm11, {{5{rnd[10]}}, rnd[10:0]});
            step();
        end
    endtask

    task automatic errorTest();
        instrU ins;
        logic  isLegal;
        for (int op = 0; op < 32; op++) begin
            ins = instrU'({5'(op), 11'h2a5});
            isLegal = 1'b0;
            foreach (legalOps[k]) begin
                if (legalOps[k] == ins.rFmt.opcode) begin
                    isLegal = 1'b1;
                end
            end
            instr = ins;
            #1;
            checkFlag("err", err, !isLegal);
            checkCtrl("ctrl", ctrl, expCtrl(ins.rFmt.opcode));
            step();
        end
        instr = encode(NOP, '0);
        fetchErr = 1'b1;
        #1;
        checkFlag("err on fetchErr", err, 1'b1);
        step();
        fetchErr = 1'b0;
        instr = encode(ADDI, {3'd1, 3'd5, 5'd9});
        stall = 1'b1;
        #1;
        checkCtrl("ctrl stalled", ctrl, expCtrl(NOP));
        step();
        stall = 1'b0;
        instr = encode(NOP, '0);
        step();
        step();
        checkTag("writeDest stalled", writeDest, '0);
    endtask

    initial begin
        rstN = 1'b0;
        instr = encode(NOP, '0);
        stall = 1'b0;
        fetchErr = 1'b0;
        wbData = '0;
        regModel = '{default: '0};
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        resetTest();
        loadTest();
        bypassTest();
        opcodeTest();
        immTest();
        errorTest();
        assertFails = uut.dstPipe.chk.failCount;
        $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
                 checks, errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/controlDecoder.sv
hw/aluControl.sv
hw/destPipe.sv
hw/regSlice.sv
hw/operandMux.sv
hw/decodeStage.sv
bench/decodeStage_assertions.sv
bench/decodeStage_tb.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decodeStage_tb
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+100

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) 2>&1 | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
